// ==== icache.f ====
+incdir+.
icache_pkg.sv
icache_sdp_ram.sv
icache_tag_match.sv
icache_refill_buffer.sv
icache_ctrl.sv
icache_top.sv
icache_asserts.sv
tb_icache.sv

// ==== icache_asserts.sv ====
// handshake rules of the cache top level
// attached to icache_top with bind from the testbench

`timescale 1ns/1ns

module icache_asserts (
  input logic              clk,
  input logic              rst_n,
  input logic              rsp_valid_o,
  input logic              rsp_ready_i,
  input icache_pkg::addr_t rsp_addr_o,
  input icache_pkg::word_t rsp_instr_o,
  input logic              ar_valid_o,
  input logic              ar_ready_i,
  input icache_pkg::addr_t ar_addr_o,
  input logic              r_ready_o
);

  // burst request stays up with the same address until taken
  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o))
    else $error("burst request dropped or changed before ar_ready_i");

  // stalled response keeps every value
  rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid_o && !rsp_ready_i |=>
      rsp_valid_o && $stable(rsp_addr_o) && $stable(rsp_instr_o))
    else $error("response changed while stalled");

  // address and data phases never overlap
  ar_r_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(ar_valid_o && r_ready_o))
    else $error("ar_valid_o and r_ready_o high together");

endmodule

// ==== icache_ctrl.sv ====
// stage-1 registers and refill FSM of the instruction cache
// drives array addressing, write enables and the fetch and burst handshakes

`timescale 1ns/1ns
`include "icache_params.svh"

module icache_ctrl (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    req_valid_i,
  input  icache_pkg::addr_t       req_addr_i,
  input  logic                    rsp_ready_i,
  input  logic                    ar_ready_i,
  input  logic                    r_valid_i,
  input  logic                    r_last_i,
  input  logic                    hit_i,
  input  icache_pkg::way_t        hit_way_i,
  input  icache_pkg::way_t        victim_way_i,
  output logic                    req_ready_o,
  output logic                    rsp_valid_o,
  output icache_pkg::addr_t       rsp_addr_o,
  output logic                    ar_valid_o,
  output icache_pkg::addr_t       ar_addr_o,
  output logic                    r_ready_o,
  output logic                    beat_o,
  output icache_pkg::index_t      raddr_o,
  output logic [`ICACHE_WAYS-1:0] line_we_o,
  output logic                    plru_we_o,
  output icache_pkg::index_t      waddr_o,
  output icache_pkg::addr_t       s1_addr_o
);

  icache_pkg::state_t state_q;
  logic               run_q;
  logic               s1_valid_q;
  icache_pkg::addr_t  s1_addr_q;
  logic               s1_advance;
  logic               req_accept;
  logic               rsp_accept;
  logic               refill_done;
  icache_pkg::index_t req_index;
  icache_pkg::index_t s1_index;

  assign req_index = req_addr_i[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
  assign s1_index  = s1_addr_q[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];

  // ==========================================================================
  // stage 1
  // ==========================================================================

  // a response is only a hit seen while no refill is running
  assign rsp_valid_o = s1_valid_q && (state_q == icache_pkg::IDLE) && hit_i;
  assign rsp_accept  = rsp_valid_o && rsp_ready_i;

  assign s1_advance  = !s1_valid_q || rsp_accept;
  // run_q keeps ready low until the first edge out of reset
  assign req_ready_o = run_q && s1_advance;
  assign req_accept  = req_valid_i && req_ready_o;

  assign rsp_addr_o = s1_addr_q;
  assign s1_addr_o  = s1_addr_q;

  // arrays follow the stage-1 index while it is held
  assign raddr_o = s1_advance ? req_index : s1_index;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_q      <= 1'b0;
      s1_valid_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (s1_advance) begin
        s1_valid_q <= req_accept;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_accept) begin
      s1_addr_q <= req_addr_i;
    end
  end

  // ==========================================================================
  // refill FSM
  // ==========================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= icache_pkg::IDLE;
    end else begin
      case (state_q)
        icache_pkg::IDLE: begin
          if (s1_valid_q && !hit_i) begin
            state_q <= icache_pkg::MISS;
          end
        end
        icache_pkg::MISS: begin
          if (ar_ready_i) begin
            state_q <= icache_pkg::REFILL;
          end
        end
        icache_pkg::REFILL: begin
          // back to IDLE replays the lookup on the freshly written line
          if (refill_done) begin
            state_q <= icache_pkg::IDLE;
          end
        end
        default: begin
          state_q <= icache_pkg::IDLE;
        end
      endcase
    end
  end

  // burst request for the whole line
  assign ar_valid_o = (state_q == icache_pkg::MISS);
  assign ar_addr_o  = {s1_addr_q[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W],
                       {(`ICACHE_OFFSET_W){1'b0}}};

  assign r_ready_o   = (state_q == icache_pkg::REFILL);
  assign beat_o      = r_valid_i && r_ready_o;
  assign refill_done = beat_o && r_last_i;

  // ==========================================================================
  // array writes
  // ==========================================================================

  // data, tag and valid of the victim way share one enable
  always_comb begin
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      line_we_o[w] = refill_done && (victim_way_i == icache_pkg::way_t'(w));
    end
  end

  // bit only flips when the hit lands on the current victim
  assign plru_we_o = rsp_accept && (hit_way_i == victim_way_i);

  assign waddr_o = s1_index;

endmodule

// ==== icache_params.svh ====
// cache geometry for the two-way instruction cache
// included by the package, the RTL and the testbench

`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// ==========================================================================
// base geometry
// ==========================================================================

`define ICACHE_WAYS 2
`define ICACHE_SETS 8
`define ICACHE_LINE_BYTES 16
`define ICACHE_ADDR_W 32

// ==========================================================================
// derived fields of a fetch address
// ==========================================================================

// byte offset inside a line
`define ICACHE_OFFSET_W ($clog2(`ICACHE_LINE_BYTES))
// set number
`define ICACHE_INDEX_W ($clog2(`ICACHE_SETS))
// everything above index and offset
`define ICACHE_TAG_W (`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)

// 32-bit instructions per line
`define ICACHE_WORDS_PER_LINE (`ICACHE_LINE_BYTES / 4)

`endif

// ==== icache_pkg.sv ====
// shared types of the instruction cache
// referenced by scoped name from the RTL and the testbench

`include "icache_params.svh"

package icache_pkg;

  // fetch or burst address
  typedef logic [`ICACHE_ADDR_W-1:0] addr_t;

  // address fields
  typedef logic [`ICACHE_TAG_W-1:0] tag_t;
  typedef logic [`ICACHE_INDEX_W-1:0] index_t;

  // one instruction, also one burst beat
  typedef logic [31:0] word_t;

  // word position inside a line
  typedef logic [$clog2(`ICACHE_WORDS_PER_LINE)-1:0] word_sel_t;

  // word 0 sits in the low bits
  typedef word_t [`ICACHE_WORDS_PER_LINE-1:0] line_t;

  // way number, also the one-bit replacement state
  typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_t;

  // refill FSM
  typedef enum logic [1:0] {
    IDLE,
    MISS,
    REFILL
  } state_t;

endpackage

// ==== icache_refill_buffer.sv ====
// gathers the burst beats of one refill into a full cache line
// the line is complete combinationally during the last beat

`timescale 1ns/1ns
`include "icache_params.svh"

module icache_refill_buffer (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              beat_i,
  input  icache_pkg::word_t r_data_i,
  input  logic              r_last_i,
  output icache_pkg::line_t line_o
);

  icache_pkg::word_sel_t                               beat_cnt_q;
  icache_pkg::word_t [`ICACHE_WORDS_PER_LINE-2:0]      words_q;

  // beat position, back to zero after the last one
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_cnt_q <= '0;
    end else if (beat_i) begin
      if (r_last_i) begin
        beat_cnt_q <= '0;
      end else begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
    end
  end

  // lower words of the line, the last beat is never stored
  always_ff @(posedge clk) begin
    if (beat_i && !r_last_i) begin
      words_q[beat_cnt_q] <= r_data_i;
    end
  end

  // current beat lands in the top word
  assign line_o = {r_data_i, words_q};

endmodule

// ==== icache_sdp_ram.sv ====
// simple dual-port array, one write port and one registered read port
// instantiated per payload for data, tag, valid and replacement state

`timescale 1ns/1ns
`include "icache_params.svh"

module icache_sdp_ram #(
  parameter type payload_t = logic
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               we_i,
  input  icache_pkg::index_t waddr_i,
  input  payload_t           wdata_i,
  input  icache_pkg::index_t raddr_i,
  output payload_t           rdata_o
);

  payload_t mem_q [`ICACHE_SETS];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // cleared contents give invalid lines and way 0 as victim
      for (int i = 0; i < `ICACHE_SETS; i++) begin
        mem_q[i] <= '0;
      end
      rdata_o <= '0;
    end else begin
      if (we_i) begin
        mem_q[waddr_i] <= wdata_i;
      end
      // write-first on a collision
      if (we_i && (waddr_i == raddr_i)) begin
        rdata_o <= wdata_i;
      end else begin
        rdata_o <= mem_q[raddr_i];
      end
    end
  end

endmodule

// ==== icache_tag_match.sv ====
// stage-1 lookup: tag compare, victim choice and instruction select
// purely combinational, fed by the array outputs and the stage-1 address

`timescale 1ns/1ns
`include "icache_params.svh"

module icache_tag_match (
  input  icache_pkg::addr_t                     addr_i,
  input  icache_pkg::tag_t  [`ICACHE_WAYS-1:0]  tags_i,
  input  logic              [`ICACHE_WAYS-1:0]  valids_i,
  input  icache_pkg::line_t [`ICACHE_WAYS-1:0]  lines_i,
  input  icache_pkg::way_t                      plru_i,
  output logic                                  hit_o,
  output icache_pkg::way_t                      hit_way_o,
  output icache_pkg::way_t                      victim_way_o,
  output icache_pkg::way_t                      plru_next_o,
  output icache_pkg::word_t                     instr_o
);

  icache_pkg::tag_t          addr_tag;
  icache_pkg::word_sel_t     word_sel;
  logic [`ICACHE_WAYS-1:0]   way_match;
  icache_pkg::way_t          hit_way;
  icache_pkg::line_t         hit_line;

  // ==========================================================================
  // address split
  // ==========================================================================

  assign addr_tag = addr_i[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];

  // word select sits just above the two byte bits
  assign word_sel = addr_i[2 +: $bits(icache_pkg::word_sel_t)];

  // ==========================================================================
  // hit detection
  // ==========================================================================

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      way_match[w] = valids_i[w] && (tags_i[w] == addr_tag);
      if (way_match[w]) begin
        hit_way = icache_pkg::way_t'(w);
      end
    end
  end

  assign hit_o     = |way_match;
  assign hit_way_o = hit_way;

  // replacement bit names the victim directly
  assign victim_way_o = plru_i;

  // point away from the way just used
  assign plru_next_o = (hit_way == plru_i) ? ~plru_i : plru_i;

  // instruction out of the matching line
  assign hit_line = lines_i[hit_way];
  assign instr_o  = hit_line[word_sel];

endmodule

// ==== icache_top.sv ====
// two-way set-associative instruction cache with burst line refill
// fetch port in, response port out, read-only burst channel to memory

`timescale 1ns/1ns
`include "icache_params.svh"

module icache_top (
  input  logic              clk,
  input  logic              rst_n,
  // fetch request
  input  logic              req_valid_i,
  input  icache_pkg::addr_t req_addr_i,
  output logic              req_ready_o,
  // response
  output logic              rsp_valid_o,
  output icache_pkg::addr_t rsp_addr_o,
  output icache_pkg::word_t rsp_instr_o,
  input  logic              rsp_ready_i,
  // burst address
  output logic              ar_valid_o,
  output icache_pkg::addr_t ar_addr_o,
  input  logic              ar_ready_i,
  // burst data
  input  logic              r_valid_i,
  input  icache_pkg::word_t r_data_i,
  input  logic              r_last_i,
  output logic              r_ready_o
);

  icache_pkg::index_t                      raddr;
  icache_pkg::index_t                      waddr;
  icache_pkg::addr_t                       s1_addr;
  icache_pkg::tag_t                        s1_tag;
  logic [`ICACHE_WAYS-1:0]                 line_we;
  logic                                    plru_we;
  logic                                    beat;
  logic                                    hit;
  icache_pkg::way_t                        hit_way;
  icache_pkg::way_t                        victim_way;
  icache_pkg::way_t                        plru_rdata;
  icache_pkg::way_t                        plru_next;
  icache_pkg::line_t                       refill_line;
  icache_pkg::tag_t  [`ICACHE_WAYS-1:0]    tags;
  logic              [`ICACHE_WAYS-1:0]    valids;
  icache_pkg::line_t [`ICACHE_WAYS-1:0]    lines;

  // tag written on refill comes from the missing address
  assign s1_tag = s1_addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];

  // ==========================================================================
  // control, lookup and refill
  // ==========================================================================

  icache_ctrl icache_ctrl_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid_i),
    .req_addr_i   (req_addr_i),
    .rsp_ready_i  (rsp_ready_i),
    .ar_ready_i   (ar_ready_i),
    .r_valid_i    (r_valid_i),
    .r_last_i     (r_last_i),
    .hit_i        (hit),
    .hit_way_i    (hit_way),
    .victim_way_i (victim_way),
    .req_ready_o  (req_ready_o),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_addr_o   (rsp_addr_o),
    .ar_valid_o   (ar_valid_o),
    .ar_addr_o    (ar_addr_o),
    .r_ready_o    (r_ready_o),
    .beat_o       (beat),
    .raddr_o      (raddr),
    .line_we_o    (line_we),
    .plru_we_o    (plru_we),
    .waddr_o      (waddr),
    .s1_addr_o    (s1_addr)
  );

  icache_tag_match icache_tag_match_inst (
    .addr_i       (s1_addr),
    .tags_i       (tags),
    .valids_i     (valids),
    .lines_i      (lines),
    .plru_i       (plru_rdata),
    .hit_o        (hit),
    .hit_way_o    (hit_way),
    .victim_way_o (victim_way),
    .plru_next_o  (plru_next),
    .instr_o      (rsp_instr_o)
  );

  icache_refill_buffer icache_refill_buffer_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .beat_i   (beat),
    .r_data_i (r_data_i),
    .r_last_i (r_last_i),
    .line_o   (refill_line)
  );

  // ==========================================================================
  // arrays
  // ==========================================================================

  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : gen_way
    icache_sdp_ram #(.payload_t(icache_pkg::line_t)) line_ram_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .we_i    (line_we[w]),
      .waddr_i (waddr),
      .wdata_i (refill_line),
      .raddr_i (raddr),
      .rdata_o (lines[w])
    );

    icache_sdp_ram #(.payload_t(icache_pkg::tag_t)) tag_ram_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .we_i    (line_we[w]),
      .waddr_i (waddr),
      .wdata_i (s1_tag),
      .raddr_i (raddr),
      .rdata_o (tags[w])
    );

    // a refill always leaves the line valid
    icache_sdp_ram #(.payload_t(logic)) valid_ram_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .we_i    (line_we[w]),
      .waddr_i (waddr),
      .wdata_i (1'b1),
      .raddr_i (raddr),
      .rdata_o (valids[w])
    );
  end

  icache_sdp_ram #(.payload_t(icache_pkg::way_t)) plru_ram_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .we_i    (plru_we),
    .waddr_i (waddr),
    .wdata_i (plru_next),
    .raddr_i (raddr),
    .rdata_o (plru_rdata)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the instruction cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_icache \
  -f icache.f \
  -o sim_icache

./obj_dir/sim_icache

// ==== tb_icache.sv ====
// testbench for the two-way instruction cache
// runs directed and random fetch streams against a reference cache model

`timescale 1ns/1ns
`include "icache_params.svh"

module tb_icache;

  localparam int BP_REQS        = 40;
  localparam int RAND_REQS      = 300;
  localparam int NUM_REQS       = 1 + 3 + 5 + BP_REQS + RAND_REQS;
  localparam int TIMEOUT_CYCLES = 40 * NUM_REQS + 200;

  logic              clk;
  logic              rst_n;
  logic              req_valid_i;
  icache_pkg::addr_t req_addr_i;
  logic              req_ready_o;
  logic              rsp_valid_o;
  icache_pkg::addr_t rsp_addr_o;
  icache_pkg::word_t rsp_instr_o;
  logic              rsp_ready_i;
  logic              ar_valid_o;
  icache_pkg::addr_t ar_addr_o;
  logic              ar_ready_i;
  logic              r_valid_i;
  icache_pkg::word_t r_data_i;
  logic              r_last_i;
  logic              r_ready_o;

  integer seed = 62140;
  string  test_name = "reset";
  logic   bp_on = 1'b0;
  int     bursts_seen = 0;
  int     cycle_cnt = 0;
  logic   in_burst = 1'b0;
  logic   lookup_due = 1'b0;
  logic   lookup_hit = 1'b0;

  // expected responses and bursts in request order
  icache_pkg::addr_t exp_addr_q [$];
  logic              exp_miss_q [$];
  int                burst_mark_q [$];
  icache_pkg::addr_t exp_burst_q [$];

  // reference cache state
  icache_pkg::tag_t model_tag [`ICACHE_SETS][`ICACHE_WAYS];
  logic             model_valid [`ICACHE_SETS][`ICACHE_WAYS];
  icache_pkg::way_t model_plru [`ICACHE_SETS];

  icache_top icache_top_inst (.*);

  bind icache_top icache_asserts icache_asserts_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_addr_o  (rsp_addr_o),
    .rsp_instr_o (rsp_instr_o),
    .ar_valid_o  (ar_valid_o),
    .ar_ready_i  (ar_ready_i),
    .ar_addr_o   (ar_addr_o),
    .r_ready_o   (r_ready_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ==========================================================================
  // reference functions
  // ==========================================================================

  // memory contents as a fixed scramble of the word address
  function automatic icache_pkg::word_t mem_word(icache_pkg::addr_t a);
    return (a * 32'h9e37_79b9) ^ {a[15:0], a[31:16]} ^ 32'h1357_9bdf;
  endfunction

  // one lookup on the model returns 1 on a miss
  function automatic logic model_access(icache_pkg::addr_t a);
    icache_pkg::index_t idx;
    icache_pkg::tag_t   tg;
    icache_pkg::way_t   w;
    logic               hit;
    idx = a[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    tg  = a[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    hit = 1'b0;
    w   = '0;
    for (int i = 0; i < `ICACHE_WAYS; i++) begin
      if (model_valid[idx][i] && (model_tag[idx][i] == tg)) begin
        hit = 1'b1;
        w   = icache_pkg::way_t'(i);
      end
    end
    // a miss fills the victim and the replay hits it
    if (!hit) begin
      w = model_plru[idx];
      model_tag[idx][w]   = tg;
      model_valid[idx][w] = 1'b1;
    end
    if (w == model_plru[idx]) begin
      model_plru[idx] = ~w;
    end
    return !hit;
  endfunction

  // ==========================================================================
  // error reporting and compare tasks
  // ==========================================================================

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(string what, icache_pkg::word_t exp, icache_pkg::word_t act);
    if (exp !== act) begin
      fail_run($sformatf("Mismatch in %s, %s: expected %h, actual %h",
                         test_name, what, exp, act));
    end
  endtask

  task automatic check_addr(string what, icache_pkg::addr_t exp, icache_pkg::addr_t act);
    if (exp !== act) begin
      fail_run($sformatf("Mismatch in %s, %s: expected %h, actual %h",
                         test_name, what, exp, act));
    end
  endtask

  task automatic check_flag(string what, logic exp, logic act);
    if (exp !== act) begin
      fail_run($sformatf("Mismatch in %s, %s: expected %b, actual %b",
                         test_name, what, exp, act));
    end
  endtask

  // ==========================================================================
  // monitor and timeout
  // ==========================================================================

  always @(posedge clk) begin : compare_proc
    icache_pkg::addr_t exp_addr;
    logic              exp_miss;
    int                mark;
    logic              miss;
    if (rst_n) begin
      // a lookup answers in the cycle after it starts unless it misses
      if (lookup_due) begin
        check_flag("response after lookup", lookup_hit, rsp_valid_o);
      end
      lookup_due = 1'b0;
      // data phase runs from the burst handshake to the last beat
      check_flag("beat ready", in_burst, r_ready_o);
      if (r_valid_i && r_ready_o && r_last_i) begin
        in_burst   = 1'b0;
        // replayed lookup hits the new line
        lookup_due = 1'b1;
        lookup_hit = 1'b1;
      end
      if (rsp_valid_o && rsp_ready_i) begin
        check_flag("request ready on consume", 1'b1, req_ready_o);
        if (exp_addr_q.size() == 0) begin
          fail_run("a response arrived with no request pending");
        end else begin
          exp_addr = exp_addr_q.pop_front();
          exp_miss = exp_miss_q.pop_front();
          mark     = burst_mark_q.pop_front();
          check_addr("response address", exp_addr, rsp_addr_o);
          check_word("instruction", mem_word(exp_addr), rsp_instr_o);
          check_flag("miss", exp_miss, bursts_seen != mark);
        end
      end
      if (ar_valid_o && ar_ready_i) begin
        if (exp_burst_q.size() == 0) begin
          fail_run("a burst was issued with no miss pending");
        end else begin
          check_addr("burst address", exp_burst_q.pop_front(), ar_addr_o);
          bursts_seen++;
          in_burst = 1'b1;
        end
      end
      if (req_valid_i && req_ready_o) begin
        miss = model_access(req_addr_i);
        exp_addr_q.push_back(req_addr_i);
        exp_miss_q.push_back(miss);
        burst_mark_q.push_back(bursts_seen);
        lookup_due = 1'b1;
        lookup_hit = !miss;
        if (miss) begin
          exp_burst_q.push_back({req_addr_i[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W],
                                 {(`ICACHE_OFFSET_W){1'b0}}});
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      fail_run($sformatf("the run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  // ==========================================================================
  // burst memory and response back-pressure
  // ==========================================================================

  initial begin : memory_model
    logic [31:0]       rnd;
    icache_pkg::addr_t burst_addr;
    int                beat;
    logic              busy;
    ar_ready_i = 1'b0;
    r_valid_i  = 1'b0;
    r_data_i   = '0;
    r_last_i   = 1'b0;
    burst_addr = '0;
    beat       = 0;
    busy       = 1'b0;
    forever begin
      @(negedge clk);
      // every offered beat is taken during refill
      if (r_valid_i) begin
        beat++;
        if (r_last_i) begin
          busy = 1'b0;
        end
      end
      if (ar_ready_i) begin
        busy = 1'b1;
        beat = 0;
      end
      ar_ready_i = 1'b0;
      r_valid_i  = 1'b0;
      r_last_i   = 1'b0;
      rnd        = $random(seed);
      if (busy) begin
        if (rnd[1:0] != 2'b00) begin
          r_valid_i = 1'b1;
          r_data_i  = mem_word(burst_addr + icache_pkg::addr_t'(beat * 4));
          r_last_i  = (beat == `ICACHE_WORDS_PER_LINE - 1);
        end
      end else if (ar_valid_o && rnd[2]) begin
        ar_ready_i = 1'b1;
        burst_addr = ar_addr_o;
      end
    end
  end

  initial begin : backpressure
    logic [31:0] rnd;
    int          stretch;
    rsp_ready_i = 1'b1;
    stretch     = 0;
    forever begin
      @(negedge clk);
      if (!bp_on) begin
        rsp_ready_i = 1'b1;
      end else if (stretch == 0) begin
        rnd         = $random(seed);
        rsp_ready_i = rnd[0];
        stretch     = int'(rnd[3:1]);
      end else begin
        stretch--;
      end
    end
  end

  // ==========================================================================
  // stimulus
  // ==========================================================================

  // holds the request until the cache accepts it
  task automatic fetch(icache_pkg::addr_t a);
    @(negedge clk);
    req_valid_i = 1'b1;
    req_addr_i  = a;
    @(posedge clk);
    while (!req_ready_o) begin
      @(posedge clk);
    end
  endtask

  task automatic drain();
    @(negedge clk);
    req_valid_i = 1'b0;
    while (exp_addr_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic fetch_random(int count);
    logic [31:0] rnd;
    for (int i = 0; i < count; i++) begin
      rnd = $random(seed);
      // 4 tags per set over all 8 sets
      fetch({23'd0, rnd[8:2], 2'b00});
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    req_valid_i = 1'b0;
    req_addr_i  = '0;
    for (int s = 0; s < `ICACHE_SETS; s++) begin
      model_plru[s] = '0;
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        model_tag[s][w]   = '0;
        model_valid[s][w] = 1'b0;
      end
    end
    repeat (3) @(negedge clk);
    check_flag("outputs low in reset", 1'b0,
               req_ready_o | rsp_valid_o | ar_valid_o | r_ready_o);
    rst_n = 1'b1;

    test_name = "cold_miss";
    fetch(32'h0000_1000);
    drain();
    check_flag("single burst", 1'b1, bursts_seen == 1);

    test_name = "line_hits";
    fetch(32'h0000_1004);
    fetch(32'h0000_1008);
    fetch(32'h0000_100c);
    drain();
    check_flag("no new burst", 1'b1, bursts_seen == 1);

    // A, B, A, C, B all map to set 5
    test_name = "replacement";
    fetch(32'h0000_2050);
    fetch(32'h0000_4050);
    fetch(32'h0000_2054);
    fetch(32'h0000_8058);
    fetch(32'h0000_405c);
    drain();
    check_flag("four bursts", 1'b1, bursts_seen == 5);

    test_name = "backpressure";
    bp_on = 1'b1;
    fetch_random(BP_REQS);
    drain();
    bp_on = 1'b0;

    test_name = "random_stream";
    fetch_random(RAND_REQS);
    drain();

    if (exp_addr_q.size() == 0 && exp_burst_q.size() == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      fail_run("requests or bursts were still outstanding at the end");
    end
  end

endmodule
